// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing
TOP       = rob_tb
FILELIST  = rob_core.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/commit_pc_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_pc_reg (
    input  wire         clk,
    input  wire         rst,
    input  wire         advance,
    input  wire  [31:0] next_pc,
    output logic [31:0] pc
);
    import rob_pkg::*;

    // Architectural pc, one step per retirement.
    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= reset_pc;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dispatch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire rob_pkg::dispatch_t dispatch,
    input  wire rob_pkg::tag_t  alloc_tag,
    output rob_pkg::alloc_t     alloc,
    output rob_pkg::issue_t     issue
);
    import isa_pkg::*;
    import rob_pkg::*;

    dispatch_t d_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            d_q.valid <= 1'b0;
        end else begin
            d_q <= dispatch;
        end
    end

    // Allocation request for the queue tail.
    always_comb begin
        alloc.valid = d_q.valid;
        alloc.op    = d_q.op;
        alloc.rd    = d_q.rd;
        alloc.imm   = d_q.imm;
        alloc.state = is_imm_ready(d_q.op) ? done : executing;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid  <= d_q.valid;
            issue.tag    <= alloc_tag;  // Tail at allocation.
            issue.op     <= d_q.op;
            issue.value1 <= d_q.value1_rf;
            issue.query1 <= d_q.query1_rf;
            if (d_q.has_imm) begin
                issue.value2 <= d_q.imm;
                issue.query2 <= '0;
            end else begin
                issue.value2 <= d_q.value2_rf;
                issue.query2 <= d_q.query2_rf;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [4:0] op_t;

    // ALU ops.
    localparam op_t op_add   = 5'd0;
    localparam op_t op_and   = 5'd1;
    localparam op_t op_or    = 5'd2;
    localparam op_t op_sll   = 5'd3;
    localparam op_t op_srl   = 5'd4;
    localparam op_t op_slt   = 5'd5;
    localparam op_t op_sltu  = 5'd6;
    localparam op_t op_sra   = 5'd7;
    localparam op_t op_sub   = 5'd8;
    localparam op_t op_xor   = 5'd9;
    localparam op_t op_beq   = 5'd10;
    localparam op_t op_bge   = 5'd11;
    localparam op_t op_bne   = 5'd12;
    localparam op_t op_bgeu  = 5'd13;
    localparam op_t op_lui   = 5'd14;
    localparam op_t op_auipc = 5'd15;
    localparam op_t op_jal   = 5'd16;
    localparam op_t op_jalr  = 5'd17;
    // Memory ops.
    localparam op_t op_lb    = 5'd18;
    localparam op_t op_lh    = 5'd19;
    localparam op_t op_lw    = 5'd20;
    localparam op_t op_lbu   = 5'd21;
    localparam op_t op_lhu   = 5'd22;
    localparam op_t op_sb    = 5'd23;
    localparam op_t op_sh    = 5'd24;
    localparam op_t op_sw    = 5'd25;
    localparam op_t op_blt   = 5'd26;
    localparam op_t op_bltu  = 5'd27;
    localparam op_t op_none  = 5'd31;  // Idle slot.

    function automatic logic is_branch(op_t op);
        return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    endfunction

    function automatic logic is_link(op_t op);
        return op inside {op_jal, op_jalr};
    endfunction

    // Result known at dispatch.
    function automatic logic is_imm_ready(op_t op);
        return op inside {op_lui, op_auipc, op_jal};
    endfunction

    function automatic logic is_mem(op_t op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
    endfunction

endpackage

`default_nettype wire

// ==== logic/redirect_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module redirect_unit (
    input  wire                   clk,
    input  wire                   rst,
    input  wire rob_pkg::retire_t retire,
    input  wire  [31:0]           pc,
    output logic                  retire_ack,
    output logic                  advance,
    output logic [31:0]           next_pc,
    output rob_pkg::commit_t      commit,
    output rob_pkg::redirect_t    redirect
);
    import isa_pkg::*;
    import rob_pkg::*;

    logic [31:0] seq_pc;
    logic [31:0] rel_pc;
    logic [31:0] wr_value;
    logic [4:0]  wr_rd;

    assign seq_pc     = pc + 32'd4;
    assign rel_pc     = pc + retire.imm;
    assign retire_ack = retire.valid;  // Never stalls.
    assign advance    = retire.valid;

    always_comb begin
        if (is_link(retire.op)) begin
            wr_value = seq_pc;
        end else if (retire.op == op_auipc) begin
            wr_value = rel_pc;
        end else if (retire.op == op_lui) begin
            wr_value = retire.imm;
        end else if (is_branch(retire.op)) begin
            wr_value = '0;
        end else begin
            wr_value = retire.value;
        end
    end

    assign wr_rd = is_branch(retire.op) ? 5'd0 : retire.rd;

    always_comb begin
        if (retire.op == op_jal) begin
            next_pc = rel_pc;
        end else if (retire.op == op_jalr) begin
            next_pc = retire.value;  // Target from the ALU.
        end else if (is_branch(retire.op) && retire.state == done) begin
            next_pc = rel_pc;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            commit.valid   <= 1'b0;
            redirect.valid <= 1'b0;
        end else begin
            commit.valid    <= retire.valid;
            commit.tag      <= retire.tag;
            commit.rd       <= wr_rd;
            commit.value    <= wr_value;
            commit.pc       <= pc;  // Pc of the retiring op.
            redirect.valid  <= retire.valid && (next_pc != seq_pc);
            redirect.target <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int tag_w     = 3;
    localparam int rob_depth = 7;  // Tag 0 is reserved.

    typedef logic [tag_w-1:0] tag_t;

    localparam logic [31:0] reset_pc = 32'h0000_0000;

    typedef enum logic [1:0] {
        executing      = 2'b00,
        ls_ready       = 2'b01,  // May retire to the load/store unit.
        done_not_taken = 2'b10,
        done           = 2'b11
    } ready_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::op_t   op;
        logic [4:0]     rd;
        logic           has_imm;
        logic [31:0]    imm;
        logic [31:0]    value1_rf;
        tag_t           query1_rf;
        logic [31:0]    value2_rf;
        tag_t           query2_rf;
    } dispatch_t;

    typedef struct packed {
        logic           valid;
        tag_t           tag;
        isa_pkg::op_t   op;
        logic [31:0]    value1;
        tag_t           query1;
        logic [31:0]    value2;
        tag_t           query2;
    } issue_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::op_t   op;
        logic [4:0]     rd;
        logic [31:0]    imm;
        ready_t         state;
    } alloc_t;

    // ALU and memory completions.
    typedef struct packed {
        logic           valid;
        tag_t           tag;
        logic [31:0]    value;
    } complete_t;

    typedef struct packed {
        logic           valid;
        tag_t           tag;
        isa_pkg::op_t   op;
        logic [4:0]     rd;
        logic [31:0]    imm;
        logic [31:0]    value;
        ready_t         state;
    } retire_t;

    typedef struct packed {
        logic           valid;
        tag_t           tag;
        logic [4:0]     rd;
        logic [31:0]    value;
        logic [31:0]    pc;
    } commit_t;

    typedef struct packed {
        logic           valid;
        tag_t           tag;
    } ls_commit_t;

    typedef struct packed {
        logic           valid;
        logic [31:0]    target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== logic/rob_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_queue (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rob_pkg::alloc_t    alloc,
    input  wire rob_pkg::complete_t alu_done,
    input  wire rob_pkg::complete_t mem_done,
    input  wire rob_pkg::tag_t      ls_ready_tag,
    input  wire                     retire_ack,
    output rob_pkg::tag_t           alloc_tag,
    output rob_pkg::retire_t        retire,
    output rob_pkg::ls_commit_t     ls_commit,
    output logic                    rob_full
);
    import isa_pkg::*;
    import rob_pkg::*;

    op_t         op_q    [1:rob_depth];
    logic [4:0]  rd_q    [1:rob_depth];
    logic [31:0] imm_q   [1:rob_depth];
    logic [31:0] value_q [1:rob_depth];
    ready_t      state_q [1:rob_depth];

    tag_t             head;
    tag_t             tail;
    logic [tag_w-1:0] count;
    logic [tag_w-1:0] count_next;
    logic             occupied;
    logic             head_ls;
    logic             take_alloc;
    logic             take_retire;

    // Wraps 7 back to 1, never 0.
    function automatic tag_t next_tag(tag_t t);
        return (t == tag_t'(rob_depth)) ? tag_t'(1) : t + tag_t'(1);
    endfunction

    assign occupied    = (count != '0);
    assign head_ls     = occupied && (state_q[head] == ls_ready);
    assign take_alloc  = alloc.valid && !rob_full;  // Dropped when full.
    assign take_retire = retire.valid && retire_ack;
    assign alloc_tag   = tail;
    assign count_next  = count + tag_w'(take_alloc) - tag_w'(take_retire);

    always_comb begin
        retire.valid = occupied &&
                       (state_q[head] == done || state_q[head] == done_not_taken);
        retire.tag   = head;
        retire.op    = op_q[head];
        retire.rd    = rd_q[head];
        retire.imm   = imm_q[head];
        retire.value = value_q[head];
        retire.state = state_q[head];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head            <= tag_t'(1);
            tail            <= tag_t'(1);
            count           <= '0;
            rob_full        <= 1'b0;
            ls_commit.valid <= 1'b0;
        end else begin
            if (take_alloc) begin
                tail <= next_tag(tail);
            end
            if (take_retire) begin
                head <= next_tag(head);
            end
            count           <= count_next;
            rob_full        <= (count_next == tag_w'(rob_depth));
            ls_commit.valid <= head_ls;
            ls_commit.tag   <= head;
        end
    end

    // Entry writes. Later statements win on the same entry.
    always_ff @(posedge clk) begin
        if (take_alloc) begin
            op_q[tail]    <= alloc.op;
            rd_q[tail]    <= alloc.rd;
            imm_q[tail]   <= alloc.imm;
            state_q[tail] <= alloc.state;
        end
        if (head_ls) begin
            state_q[head] <= executing;  // Now waits for memory data.
        end
        if (alu_done.valid) begin
            if (is_branch(op_q[alu_done.tag])) begin
                // Taken branch keeps its offset in imm.
                state_q[alu_done.tag] <= (alu_done.value == '0) ? done_not_taken : done;
            end else begin
                value_q[alu_done.tag] <= alu_done.value;
                state_q[alu_done.tag] <= done;
            end
        end
        if (mem_done.valid) begin
            value_q[mem_done.tag] <= mem_done.value;
            state_q[mem_done.tag] <= done;
        end
        if (ls_ready_tag != '0 && is_mem(op_q[ls_ready_tag])) begin
            state_q[ls_ready_tag] <= ls_ready;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rob_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rob_pkg::dispatch_t dispatch,
    input  wire rob_pkg::complete_t alu_done,
    input  wire rob_pkg::complete_t mem_done,
    input  wire rob_pkg::tag_t      ls_ready_tag,
    output rob_pkg::issue_t         issue,
    output rob_pkg::commit_t        commit,
    output rob_pkg::ls_commit_t     ls_commit,
    output rob_pkg::redirect_t      redirect,
    output logic                    rob_full,
    output logic [31:0]             arch_pc
);
    import rob_pkg::*;

    alloc_t      alloc;
    tag_t        alloc_tag;
    retire_t     retire;
    logic        retire_ack;
    logic        advance;
    logic [31:0] next_pc;

    dispatch_stage u_dispatch_stage (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (dispatch),
        .alloc_tag (alloc_tag),
        .alloc     (alloc),
        .issue     (issue)
    );

    rob_queue u_rob_queue (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alu_done     (alu_done),
        .mem_done     (mem_done),
        .ls_ready_tag (ls_ready_tag),
        .retire_ack   (retire_ack),
        .alloc_tag    (alloc_tag),
        .retire       (retire),
        .ls_commit    (ls_commit),
        .rob_full     (rob_full)
    );

    commit_pc_reg u_commit_pc_reg (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .next_pc (next_pc),
        .pc      (arch_pc)
    );

    redirect_unit u_redirect_unit (
        .clk        (clk),
        .rst        (rst),
        .retire     (retire),
        .pc         (arch_pc),
        .retire_ack (retire_ack),
        .advance    (advance),
        .next_pc    (next_pc),
        .commit     (commit),
        .redirect   (redirect)
    );

endmodule

`default_nettype wire

// ==== rob_core.f ====
logic/isa_pkg.sv
logic/rob_pkg.sv
logic/dispatch_stage.sv
logic/rob_queue.sv
logic/commit_pc_reg.sv
logic/redirect_unit.sv
logic/rob_top.sv
tests/rob_checker.sv
tests/rob_monitor.sv
tests/rob_tb.sv

// ==== tests/rob_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_checker (
    input  wire                      clk,
    input  wire                      rst,
    input  wire rob_pkg::dispatch_t  dispatch,
    input  wire rob_pkg::issue_t     issue,
    input  wire rob_pkg::commit_t    commit,
    input  wire rob_pkg::ls_commit_t ls_commit,
    input  wire rob_pkg::redirect_t  redirect,
    input  wire                      rob_full
);

    // Dispatcher must respect back-pressure.
    a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (!rst)
        !(dispatch.valid && rob_full))
        else $error("dispatch while rob_full");

    a_idle_in_reset: assert property (@(posedge clk)
        !rst |=> (!issue.valid && !commit.valid && !ls_commit.valid &&
                  !redirect.valid && !rob_full))
        else $error("outputs active during reset");

    // One retirement per cycle.
    a_single_retire: assert property (@(posedge clk) disable iff (!rst)
        !(commit.valid && ls_commit.valid))
        else $error("commit and ls_commit together");

    a_commit_tag: assert property (@(posedge clk) disable iff (!rst)
        commit.valid |-> commit.tag != '0)
        else $error("commit with tag 0");

endmodule

`default_nettype wire

// ==== tests/rob_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_monitor (
    input  wire                      clk,
    input  wire                      rst,
    input  wire rob_pkg::issue_t     issue,
    input  wire rob_pkg::commit_t    commit,
    input  wire rob_pkg::ls_commit_t ls_commit,
    input  wire rob_pkg::redirect_t  redirect,
    input  wire                      rob_full,
    input  wire [31:0]               arch_pc
);
    import isa_pkg::*;
    import rob_pkg::*;

    typedef struct packed {
        op_t         op;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] result;
        tag_t        tag;
    } rec_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic [31:0] next_pc;
        logic        redir;
    } expect_t;

    rec_t        recs[$];
    issue_t      issues[$];
    tag_t        tag_model = tag_t'(1);
    logic [31:0] model_pc = reset_pc;
    logic        ls_seen = 1'b0;
    int          ls_count = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          passed = 0;
    int          failed = 0;
    string       test_name = "none";

    // Expected retirement of one op at the given pc.
    function automatic expect_t reference(rec_t r, logic [31:0] pc);
        expect_t e;
        logic    taken;
        taken = is_branch(r.op) && (r.result != '0);
        e.rd = is_branch(r.op) ? 5'd0 : r.rd;
        if (r.op == op_jal || r.op == op_jalr) e.value = pc + 32'd4;
        else if (r.op == op_auipc) e.value = pc + r.imm;
        else if (r.op == op_lui) e.value = r.imm;
        else if (is_branch(r.op)) e.value = '0;
        else e.value = r.result;
        if (r.op == op_jal || taken) e.next_pc = pc + r.imm;
        else if (r.op == op_jalr) e.next_pc = r.result;
        else e.next_pc = pc + 32'd4;
        e.redir = (e.next_pc != pc + 32'd4);
        return e;
    endfunction

    task automatic expect_dispatch(input dispatch_t d, input logic [31:0] result,
                                   output tag_t tag);
        issue_t i;
        rec_t   r;
        i.valid  = 1'b1;
        i.tag    = tag_model;
        i.op     = d.op;
        i.value1 = d.value1_rf;
        i.query1 = d.query1_rf;
        i.value2 = d.has_imm ? d.imm : d.value2_rf;
        i.query2 = d.has_imm ? tag_t'(0) : d.query2_rf;
        issues.push_back(i);
        r.op     = d.op;
        r.rd     = d.rd;
        r.imm    = d.imm;
        r.result = result;
        r.tag    = tag_model;
        recs.push_back(r);
        tag = tag_model;
        tag_model = (tag_model == tag_t'(rob_depth)) ? tag_t'(1) : tag_model + tag_t'(1);
    endtask

    task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, field, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic fault(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_full(input logic exp);
        compare("rob_full", 32'(exp), 32'(rob_full));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Test %s: ok", test_name);
            passed++;
        end else begin
            $display("Test %s: %0d errors", test_name, test_errors);
            failed++;
        end
    endtask

    task automatic print_counts();
        $display("Tests: %0d ok, %0d failing, %0d errors in total", passed, failed, errors);
    endtask

    function automatic int outstanding();
        return recs.size();
    endfunction

    function automatic int issues_left();
        return issues.size();
    endfunction

    always @(posedge clk) begin
        rec_t    r;
        expect_t e;
        if (rst) begin
            if (issue.valid) begin
                if (issues.size() == 0) begin
                    fault("issue with nothing dispatched");
                end else begin
                    compare("issue.tag", 32'(issues[0].tag), 32'(issue.tag));
                    compare("issue.op", 32'(issues[0].op), 32'(issue.op));
                    compare("issue.value1", issues[0].value1, issue.value1);
                    compare("issue.query1", 32'(issues[0].query1), 32'(issue.query1));
                    compare("issue.value2", issues[0].value2, issue.value2);
                    compare("issue.query2", 32'(issues[0].query2), 32'(issue.query2));
                    void'(issues.pop_front());
                end
            end
            if (ls_commit.valid) begin
                if (recs.size() == 0 || !is_mem(recs[0].op) || ls_seen) begin
                    fault("unexpected ls_commit");
                end else begin
                    compare("ls_commit.tag", 32'(recs[0].tag), 32'(ls_commit.tag));
                    ls_seen = 1'b1;
                    ls_count++;
                end
            end
            if (commit.valid) begin
                if (recs.size() == 0) begin
                    fault("commit with nothing outstanding");
                end else begin
                    r = recs.pop_front();
                    e = reference(r, model_pc);
                    if (is_mem(r.op) && !ls_seen) fault("memory op committed without ls_commit");
                    compare("commit.tag", 32'(r.tag), 32'(commit.tag));
                    compare("commit.rd", 32'(e.rd), 32'(commit.rd));
                    compare("commit.value", e.value, commit.value);
                    compare("commit.pc", model_pc, commit.pc);
                    compare("redirect.valid", 32'(e.redir), 32'(redirect.valid));
                    if (e.redir) compare("redirect.target", e.next_pc, redirect.target);
                    compare("arch_pc", e.next_pc, arch_pc);
                    model_pc = e.next_pc;
                    ls_seen = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/rob_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_tb;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int cycle_limit = 200 * 6;

    logic        clk = 1'b0;
    logic        rst;
    dispatch_t   dispatch;
    complete_t   alu_done;
    complete_t   mem_done;
    tag_t        ls_ready_tag;
    issue_t      issue;
    commit_t     commit;
    ls_commit_t  ls_commit;
    redirect_t   redirect;
    logic        rob_full;
    logic [31:0] arch_pc;

    logic [31:0] seed = 32'hc982;
    int          cycles = 0;
    tag_t        tags[8];
    logic [31:0] vals[8];
    int          order[8];

    always #20 clk = ~clk;

    rob_top u_rob_top (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .alu_done     (alu_done),
        .mem_done     (mem_done),
        .ls_ready_tag (ls_ready_tag),
        .issue        (issue),
        .commit       (commit),
        .ls_commit    (ls_commit),
        .redirect     (redirect),
        .rob_full     (rob_full),
        .arch_pc      (arch_pc)
    );

    rob_monitor u_monitor (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .commit    (commit),
        .ls_commit (ls_commit),
        .redirect  (redirect),
        .rob_full  (rob_full),
        .arch_pc   (arch_pc)
    );

    bind rob_top rob_checker u_rob_checker (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (dispatch),
        .issue     (issue),
        .commit    (commit),
        .ls_commit (ls_commit),
        .redirect  (redirect),
        .rob_full  (rob_full)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // Word aligned offset, never zero.
    function logic [31:0] rand_offset();
        logic [31:0] r;
        r = next_rand();
        return {20'd0, r[11:2], 2'b00} + 32'd8;
    endfunction

    task automatic send(input op_t op, input logic [4:0] rd, input logic has_imm,
                        input logic [31:0] imm, input logic [31:0] v1, input tag_t q1,
                        input logic [31:0] v2, input tag_t q2, input logic [31:0] result,
                        output tag_t tag);
        dispatch_t d;
        d.valid     = 1'b1;
        d.op        = op;
        d.rd        = rd;
        d.has_imm   = has_imm;
        d.imm       = imm;
        d.value1_rf = v1;
        d.query1_rf = q1;
        d.value2_rf = v2;
        d.query2_rf = q2;
        @(posedge clk);
        dispatch <= d;
        u_monitor.expect_dispatch(d, result, tag);
    endtask

    task automatic end_dispatch();
        @(posedge clk);
        dispatch.valid <= 1'b0;
    endtask

    task automatic wait_issued();
        while (u_monitor.issues_left() != 0) @(posedge clk);
    endtask

    task automatic wait_drained();
        while (u_monitor.outstanding() != 0) @(posedge clk);
    endtask

    task automatic complete_alu(input tag_t tag, input logic [31:0] value);
        @(posedge clk);
        alu_done <= '{valid: 1'b1, tag: tag, value: value};
        @(posedge clk);
        alu_done.valid <= 1'b0;
    endtask

    task automatic complete_mem(input tag_t tag, input logic [31:0] value);
        @(posedge clk);
        mem_done <= '{valid: 1'b1, tag: tag, value: value};
        @(posedge clk);
        mem_done.valid <= 1'b0;
    endtask

    // Pulses ls_ready and waits for the matching ls_commit.
    task automatic mark_ls_ready(input tag_t tag);
        int seen;
        seen = u_monitor.ls_count;
        @(posedge clk);
        ls_ready_tag <= tag;
        @(posedge clk);
        ls_ready_tag <= '0;
        while (u_monitor.ls_count == seen) @(posedge clk);
    endtask

    task automatic shuffle(input int n);
        int j;
        int t;
        for (int i = 0; i < n; i++) order[i] = i;
        for (int i = n - 1; i > 0; i--) begin
            j = int'(next_rand() % (i + 1));
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Run hung: no progress within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst          <= 1'b0;
        dispatch     <= '0;
        alu_done     <= '0;
        mem_done     <= '0;
        ls_ready_tag <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        u_monitor.start_test("alu_in_order");
        for (int i = 0; i < 5; i++) begin
            vals[i] = next_rand();
            send(op_add, 5'(i + 1), 1'b0, '0, next_rand(), '0, next_rand(), '0, vals[i],
                 tags[i]);
        end
        end_dispatch();
        wait_issued();
        shuffle(5);
        for (int i = 0; i < 5; i++) complete_alu(tags[order[i]], vals[order[i]]);
        wait_drained();
        u_monitor.finish_test();

        u_monitor.start_test("imm_ready");
        send(op_lui, 5'd3, 1'b1, next_rand() & 32'hffff_f000, '0, '0, '0, '0, '0, tags[0]);
        send(op_auipc, 5'd4, 1'b1, rand_offset(), '0, '0, '0, '0, '0, tags[1]);
        send(op_jal, 5'd1, 1'b1, rand_offset(), '0, '0, '0, '0, '0, tags[2]);
        end_dispatch();
        wait_drained();
        u_monitor.finish_test();

        u_monitor.start_test("branch_jalr");
        vals[0] = 32'd0;
        vals[1] = 32'd1;
        vals[2] = 32'd0;
        vals[3] = rand_offset() + 32'h100;
        send(op_beq, 5'd5, 1'b0, rand_offset(), '0, '0, '0, '0, vals[0], tags[0]);
        send(op_bne, 5'd6, 1'b0, rand_offset(), '0, '0, '0, '0, vals[1], tags[1]);
        send(op_bltu, 5'd7, 1'b0, rand_offset(), '0, '0, '0, '0, vals[2], tags[2]);
        send(op_jalr, 5'd1, 1'b1, 32'd0, '0, '0, '0, '0, vals[3], tags[3]);
        end_dispatch();
        wait_issued();
        for (int i = 0; i < 4; i++) complete_alu(tags[i], vals[i]);
        wait_drained();
        u_monitor.finish_test();

        u_monitor.start_test("load_store");
        for (int i = 0; i < 3; i++) vals[i] = next_rand();
        send(op_lw, 5'd8, 1'b1, 32'd16, next_rand(), '0, '0, '0, vals[0], tags[0]);
        send(op_sw, 5'd0, 1'b1, 32'd20, next_rand(), '0, '0, '0, vals[1], tags[1]);
        send(op_lbu, 5'd9, 1'b1, 32'd3, next_rand(), '0, '0, '0, vals[2], tags[2]);
        end_dispatch();
        wait_issued();
        for (int i = 0; i < 3; i++) begin
            mark_ls_ready(tags[i]);
            complete_mem(tags[i], vals[i]);
        end
        wait_drained();
        u_monitor.finish_test();

        u_monitor.start_test("back_pressure");
        for (int i = 0; i < 7; i++) begin
            vals[i] = next_rand();
            send(op_sub, 5'(i + 10), 1'b0, '0, next_rand(), '0, next_rand(), '0, vals[i],
                 tags[i]);
        end
        end_dispatch();
        wait_issued();
        u_monitor.check_full(1'b1);
        shuffle(7);
        for (int i = 0; i < 7; i++) complete_alu(tags[order[i]], vals[order[i]]);
        wait_drained();
        u_monitor.check_full(1'b0);
        u_monitor.finish_test();

        u_monitor.start_test("operand_select");
        for (int i = 0; i < 4; i++) vals[i] = next_rand();
        send(op_add, 5'd20, 1'b1, next_rand(), next_rand(), 3'd2, next_rand(), 3'd5, vals[0],
             tags[0]);
        send(op_sub, 5'd21, 1'b0, next_rand(), next_rand(), 3'd1, next_rand(), 3'd6, vals[1],
             tags[1]);
        send(op_xor, 5'd22, 1'b1, next_rand(), next_rand(), 3'd0, next_rand(), 3'd4, vals[2],
             tags[2]);
        send(op_or, 5'd23, 1'b0, next_rand(), next_rand(), 3'd7, next_rand(), 3'd3, vals[3],
             tags[3]);
        end_dispatch();
        wait_issued();
        for (int i = 0; i < 4; i++) complete_alu(tags[i], vals[i]);
        wait_drained();
        u_monitor.finish_test();

        u_monitor.print_counts();
        if (u_monitor.errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
